// File: common/uartPkg.sv
package uartPkg;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam logic [1:0] addrBrg = 2'd0;  // Baud divisor.
  localparam logic [1:0] addrCtl = 2'd1;  // Control and status.
  localparam logic [1:0] addrTxr = 2'd2;  // Transmit byte.
  localparam logic [1:0] addrRxr = 2'd3;  // Receive byte.

  ////////////////////////////////////////
  // Frame format
  ////////////////////////////////////////

  // Start bit, eight data bits, stop bit.
  localparam int frameBits = 10;

  ////////////////////////////////////////
  // Control/status word
  ////////////////////////////////////////

  typedef struct packed {
    logic [9:0] rsvdHi;  // Always zero.
    logic       rxNew;   // Unread receive byte.
    logic       txBusy;  // Frame in flight.
    logic [2:0] rsvdLo;  // Always zero.
    logic       enable;  // Bit 0.
  } ctlStatusS;

  // Bus sees the raw word, logic sees the fields.
  typedef union packed {
    logic [15:0] raw;
    ctlStatusS   fields;
  } ctlStatusU;

endpackage

// File: verilog/uartBusRegs.sv
`timescale 1ns/100ps

module uartBusRegs import uartPkg::*; #(
  parameter int divWidth = 16
) (
  input  logic                clk,
  input  logic                rstN,
  // Bus side.
  input  logic                busEn,
  input  logic                busWr,
  input  logic [1:0]          busAddr,
  inout  wire  [15:0]         busData,
  // Engine status.
  input  logic                txBusy,
  input  logic                rxNew,
  input  logic [7:0]          rxByte,
  // Engine control.
  output logic [divWidth-1:0] baudDiv,
  output logic                enable,
  output logic                txStart,
  output logic [7:0]          txByte,
  output logic                rxRead
);

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  logic        regWr;     // Bus write strobe.
  logic        regRd;     // Bus read strobe.
  logic        brgWr;
  logic        ctlWr;
  logic        txrWr;
  logic [7:0]  txByteQ;   // Last accepted byte.
  logic [15:0] readData;  // Read-back mux output.
  ctlStatusU   ctlWord;

  assign regWr = busEn & busWr;
  assign regRd = busEn & ~busWr;

  assign brgWr = regWr & (busAddr == addrBrg);
  assign ctlWr = regWr & (busAddr == addrCtl);
  assign txrWr = regWr & (busAddr == addrTxr);

  // Accepted only when enabled and idle.
  assign txStart = txrWr & enable & ~txBusy;

  // Read of receive register, clears rxNew.
  assign rxRead = regRd & (busAddr == addrRxr);

  // Byte goes straight from the bus on a start.
  always_comb begin
    if (txStart) begin
      txByte = busData[7:0];
    end else begin
      txByte = txByteQ;
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      baudDiv <= '0;
    end else if (brgWr) begin
      baudDiv <= divWidth'(busData);  // Truncated to divisor width.
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      enable <= 1'b0;
    end else if (ctlWr) begin
      enable <= busData[0];  // Status bits are read-only.
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      txByteQ <= 8'h00;
    end else if (txStart) begin
      txByteQ <= busData[7:0];  // Ignored writes leave it alone.
    end
  end

  ////////////////////////////////////////
  // Read-back
  ////////////////////////////////////////

  // Status word.
  always_comb begin
    ctlWord.raw           = '0;
    ctlWord.fields.enable = enable;
    ctlWord.fields.txBusy = txBusy;
    ctlWord.fields.rxNew  = rxNew;
  end

  always_comb begin
    case (busAddr)
      addrBrg: readData = 16'(baudDiv);  // Zero extended.
      addrCtl: readData = ctlWord.raw;
      addrTxr: readData = {8'h00, txByteQ};
      default: readData = {8'h00, rxByte};
    endcase
  end

  // Drive only during a read cycle.
  assign busData = regRd ? readData : 16'hzzzz;

endmodule

// File: uartTx/uartTx.sv
`timescale 1ns/100ps

module uartTx import uartPkg::*; #(
  parameter int divWidth = 16
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                enable,
  input  logic [divWidth-1:0] baudDiv,
  input  logic                txStart,
  input  logic [7:0]          txByte,
  output logic                txBusy,
  output logic                txOut,
  output logic                txInt
);

  localparam int cntWidth = $clog2(frameBits);

  logic [divWidth-1:0]  baudCnt;   // Cycles into current bit.
  logic [cntWidth-1:0]  bitCnt;    // Bits already sent.
  logic [frameBits-1:0] shiftReg;  // Line bit at index 0.
  logic                 baudMatch;
  logic                 lastBit;

  ////////////////////////////////////////
  // Bit timing
  ////////////////////////////////////////

  assign baudMatch = (baudCnt == baudDiv);       // End of bit period.
  assign lastBit   = (bitCnt == cntWidth'(frameBits - 1));  // Stop bit.

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      baudCnt <= '0;
    end else if (!enable || txStart || baudMatch) begin
      baudCnt <= '0;
    end else if (txBusy) begin
      baudCnt <= baudCnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      bitCnt <= '0;
    end else if (!enable || txStart) begin
      bitCnt <= '0;
    end else if (txBusy && baudMatch) begin
      bitCnt <= bitCnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Frame state
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      txBusy <= 1'b0;
      txInt  <= 1'b0;
    end else begin
      txInt <= 1'b0;                           // Pulse by default.
      if (!enable) begin
        txBusy <= 1'b0;                        // Abort, no interrupt.
      end else if (txStart) begin
        txBusy <= 1'b1;
      end else if (txBusy && baudMatch && lastBit) begin
        txBusy <= 1'b0;
        txInt  <= 1'b1;                        // Same edge busy drops.
      end
    end
  end

  // Load stop, data, start; shift ones in behind.
  always_ff @(posedge clk) begin
    if (txStart) begin
      shiftReg <= {1'b1, txByte, 1'b0};
    end else if (txBusy && baudMatch) begin
      shiftReg <= {1'b1, shiftReg[frameBits-1:1]};
    end
  end

  // High when enabled and idle, or sending a one.
  assign txOut = enable & (~txBusy | shiftReg[0]);

endmodule

// File: uartRx/uartRx.sv
`timescale 1ns/100ps

module uartRx import uartPkg::*; #(
  parameter int divWidth = 16
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                enable,
  input  logic [divWidth-1:0] baudDiv,
  input  logic                rxIn,
  input  logic                rxRead,
  output logic [7:0]          rxByte,
  output logic                rxNew,
  output logic                rxInt
);

  localparam int cntWidth = $clog2(frameBits);

  logic                 rxBusy;     // Frame in progress.
  logic [divWidth-1:0]  baudCnt;    // Cycles into current bit.
  logic [cntWidth-1:0]  bitCnt;     // Bits already received.
  logic [frameBits-1:0] shiftReg;   // Newest sample at the top.
  logic [frameBits-1:0] shiftNext;
  logic                 beginRx;
  logic                 baudMatch;
  logic                 takeSample;
  logic                 lastBit;
  logic                 frameEnd;

  ////////////////////////////////////////
  // Bit timing
  ////////////////////////////////////////

  assign beginRx    = enable & ~rxBusy & ~rxIn;          // Start bit edge.
  assign baudMatch  = (baudCnt == baudDiv);
  assign takeSample = rxBusy & (baudCnt == (baudDiv >> 1));  // Mid-bit.
  assign lastBit    = (bitCnt == cntWidth'(frameBits - 1));
  assign frameEnd   = rxBusy & baudMatch & lastBit;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      baudCnt <= '0;
    end else if (!enable || beginRx || baudMatch) begin
      baudCnt <= '0;
    end else if (rxBusy) begin
      baudCnt <= baudCnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      bitCnt <= '0;
    end else if (!enable || beginRx) begin
      bitCnt <= '0;
    end else if (rxBusy && baudMatch) begin
      bitCnt <= bitCnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Sampling
  ////////////////////////////////////////

  // Includes a sample landing on the final edge.
  always_comb begin
    if (takeSample) begin
      shiftNext = {rxIn, shiftReg[frameBits-1:1]};
    end else begin
      shiftNext = shiftReg;
    end
  end

  always_ff @(posedge clk) begin
    shiftReg <= shiftNext;
  end

  ////////////////////////////////////////
  // Frame state and status
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rxBusy <= 1'b0;
      rxInt  <= 1'b0;
    end else begin
      rxInt <= frameEnd & enable;  // One cycle at frame end.
      if (!enable || frameEnd) begin
        rxBusy <= 1'b0;
      end else if (beginRx) begin
        rxBusy <= 1'b1;
      end
    end
  end

  // Data bits sit between start and stop.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rxByte <= 8'h00;
    end else if (frameEnd && enable) begin
      rxByte <= shiftNext[8:1];  // Overwrites an unread byte.
    end
  end

  // Set beats clear when both land together.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rxNew <= 1'b0;
    end else if (frameEnd && enable) begin
      rxNew <= 1'b1;
    end else if (rxRead) begin
      rxNew <= 1'b0;
    end
  end

endmodule

// File: verilog/uart.sv
`timescale 1ns/100ps

module uart #(
  parameter int divWidth = 16
) (
  input  logic        clk,
  input  logic        rstN,
  // Bus.
  input  logic        busEn,
  input  logic        busWr,
  input  logic [1:0]  busAddr,
  inout  wire  [15:0] busData,
  // Serial pins and interrupts.
  input  logic        rxIn,
  output logic        txOut,
  output logic        txInt,
  output logic        rxInt
);

  logic [divWidth-1:0] baudDiv;  // Shared by both engines.
  logic                enable;
  logic                txStart;
  logic [7:0]          txByte;
  logic                txBusy;
  logic                rxRead;
  logic [7:0]          rxByte;
  logic                rxNew;

  ////////////////////////////////////////
  // Register block
  ////////////////////////////////////////

  uartBusRegs #(.divWidth(divWidth)) busRegs (
    .clk     (clk),
    .rstN    (rstN),
    .busEn   (busEn),
    .busWr   (busWr),
    .busAddr (busAddr),
    .busData (busData),
    .txBusy  (txBusy),
    .rxNew   (rxNew),
    .rxByte  (rxByte),
    .baudDiv (baudDiv),
    .enable  (enable),
    .txStart (txStart),
    .txByte  (txByte),
    .rxRead  (rxRead)
  );

  ////////////////////////////////////////
  // Engines
  ////////////////////////////////////////

  uartTx #(.divWidth(divWidth)) tx (
    .clk     (clk),
    .rstN    (rstN),
    .enable  (enable),
    .baudDiv (baudDiv),
    .txStart (txStart),
    .txByte  (txByte),
    .txBusy  (txBusy),
    .txOut   (txOut),
    .txInt   (txInt)
  );

  uartRx #(.divWidth(divWidth)) rx (
    .clk     (clk),
    .rstN    (rstN),
    .enable  (enable),
    .baudDiv (baudDiv),
    .rxIn    (rxIn),
    .rxRead  (rxRead),
    .rxByte  (rxByte),
    .rxNew   (rxNew),
    .rxInt   (rxInt)
  );

endmodule

// File: test/uartTb.sv
`timescale 1ns/100ps

module uartTb import uartPkg::*; ();

  localparam int clkPeriod   = 20;
  localparam int resetCycles = 8;
  localparam int numTx       = 20;
  localparam int numRx       = 20;
  localparam int frameCount  = numTx + numRx + 2;  // Plus busy and disable frames.
  localparam int divSmall    = 3;
  localparam int bitCycles   = divSmall + 1;       // Cycles per line bit.
  localparam int timeLimit   = 2 * frameCount * frameBits * bitCycles * clkPeriod
                               + resetCycles * clkPeriod;

  logic        clk;
  logic        rstN;
  logic        busEn;
  logic        busWr;
  logic [1:0]  busAddr;
  logic        rxIn;
  wire  [15:0] busData;
  logic        txOut;
  logic        txInt;
  logic        rxInt;

  logic [15:0] busDrive;    // Testbench side of the bus.
  logic        busDriveEn;
  int          errReg;
  int          errTx;
  int          errRx;
  int          txIntCount;
  int          rxIntCount;
  int          txFramesDone;  // Frames checked by the monitor.
  int          txFramesWant;
  int          txIntBefore;
  int          rxIntBefore;
  int          seedDummy;
  logic [7:0]  txExpect[$];   // Bytes the monitor should see.
  logic [15:0] rdData;
  logic [15:0] dataWord;
  logic [7:0]  dataByte;
  logic [7:0]  dataByte2;
  ctlStatusU   status;

  uart #(.divWidth(16)) dut (
    .clk     (clk),
    .rstN    (rstN),
    .busEn   (busEn),
    .busWr   (busWr),
    .busAddr (busAddr),
    .busData (busData),
    .rxIn    (rxIn),
    .txOut   (txOut),
    .txInt   (txInt),
    .rxInt   (rxInt)
  );

  assign busData = busDriveEn ? busDrive : 16'hzzzz;

  initial begin
    clk = 1'b0;
    forever begin
      #(clkPeriod / 2) clk = ~clk;
    end
  end

  ////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////

  // Line sequence of an 8N1 frame, index 0 first.
  function automatic logic [frameBits-1:0] frameOf(input logic [7:0] value);
    logic [frameBits-1:0] frame;
    frame[0] = 1'b0;               // Start bit.
    for (int i = 0; i < 8; i++) begin
      frame[i + 1] = value[i];     // LSB first.
    end
    frame[frameBits - 1] = 1'b1;   // Stop bit.
    return frame;
  endfunction

  // Area 0 register, 1 transmit, 2 receive.
  task automatic expectEq(input string name, input logic [15:0] got,
                          input logic [15:0] exp, input int area);
    assert (got === exp) else begin
      $display("FAIL %s: expected %h, got %h", name, exp, got);
      case (area)
        0:       errReg++;
        1:       errTx++;
        default: errRx++;
      endcase
    end
  endtask

  task automatic busWrite(input logic [1:0] addr, input logic [15:0] data);
    @(posedge clk);
    busEn      <= 1'b1;
    busWr      <= 1'b1;
    busAddr    <= addr;
    busDrive   <= data;
    busDriveEn <= 1'b1;
    @(posedge clk);                // Captured on this edge.
    busEn      <= 1'b0;
    busWr      <= 1'b0;
    busDriveEn <= 1'b0;
  endtask

  task automatic busRead(input logic [1:0] addr, output logic [15:0] data);
    @(posedge clk);
    busEn      <= 1'b1;
    busWr      <= 1'b0;
    busAddr    <= addr;
    busDriveEn <= 1'b0;
    @(negedge clk);
    data = busData;                // Mid-cycle, bus settled.
    @(posedge clk);
    busEn <= 1'b0;
  endtask

  // Drives one frame on rxIn, one bit per period.
  task automatic sendRxFrame(input logic [7:0] value);
    logic [frameBits-1:0] line;
    line = frameOf(value);
    for (int k = 0; k < frameBits; k++) begin
      @(posedge clk);
      rxIn <= line[k];
      repeat (bitCycles - 1) @(posedge clk);
    end
  endtask

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (txInt) txIntCount++;
    if (rxInt) rxIntCount++;
  end

  // Samples txOut at bit centres, compares with the reference frame.
  initial begin : txMonitor
    logic [7:0]           monByte;
    logic [frameBits-1:0] monExp;
    logic [frameBits-1:0] monLine;
    forever begin
      wait (txExpect.size() > 0);
      @(negedge txOut);            // Start bit begins.
      monByte = txExpect.pop_front();
      monExp  = frameOf(monByte);
      repeat (bitCycles / 2) @(posedge clk);
      for (int k = 0; k < frameBits; k++) begin
        @(negedge clk);
        monLine[k] = txOut;
        if (k < frameBits - 1) begin
          repeat (bitCycles - 1) @(negedge clk);
        end
      end
      expectEq("txOut", 16'(monLine), 16'(monExp), 1);
      repeat (bitCycles - bitCycles / 2 - 1) @(negedge clk);
      expectEq("txInt", 16'(txInt), 16'h0000, 1);  // Last cycle of stop bit.
      @(negedge clk);
      expectEq("txInt", 16'(txInt), 16'h0001, 1);  // Edge where busy drops.
      txFramesDone++;
    end
  end

  initial begin : watchdog
    #(timeLimit);
    $display("Timeout: run did not finish within %0d ns", timeLimit);
    $display("Errors: register %0d, transmit %0d, receive %0d", errReg, errTx, errRx);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    seedDummy  = $urandom(32'h48f17c7b);
    rstN       = 1'b0;
    busEn      = 1'b0;
    busWr      = 1'b0;
    busAddr    = 2'd0;
    busDrive   = 16'h0000;
    busDriveEn = 1'b0;
    rxIn       = 1'b1;             // Line idles high.
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;

    // Reset state.
    for (int a = 0; a < 4; a++) begin
      busRead(2'(a), rdData);
      expectEq($sformatf("busData[addr %0d]", a), rdData, 16'h0000, 0);
    end
    expectEq("txOut", 16'(txOut), 16'h0000, 0);
    expectEq("txInt count", 16'(txIntCount), 16'h0000, 0);
    expectEq("rxInt count", 16'(rxIntCount), 16'h0000, 0);

    // Register access.
    dataWord = 16'($urandom);
    busWrite(addrBrg, dataWord);
    busRead(addrBrg, rdData);
    expectEq("baudDiv", rdData, dataWord, 0);
    busWrite(addrBrg, 16'(divSmall));
    busWrite(addrCtl, 16'hffff);   // Only enable is writable.
    busRead(addrCtl, rdData);
    status.raw = rdData;
    expectEq("ctl", status.raw, 16'h0001, 0);
    expectEq("enable", 16'(status.fields.enable), 16'h0001, 0);
    expectEq("txBusy", 16'(status.fields.txBusy), 16'h0000, 0);
    expectEq("rxNew", 16'(status.fields.rxNew), 16'h0000, 0);

    // Transmit.
    for (int n = 0; n < numTx; n++) begin
      dataByte    = 8'($urandom);
      txIntBefore = txIntCount;
      txFramesWant++;
      txExpect.push_back(dataByte);
      busWrite(addrTxr, {8'h00, dataByte});
      busRead(addrCtl, rdData);
      status.raw = rdData;
      expectEq("txBusy", 16'(status.fields.txBusy), 16'h0001, 1);
      wait (txFramesDone == txFramesWant);
      busRead(addrCtl, rdData);
      status.raw = rdData;
      expectEq("txBusy", 16'(status.fields.txBusy), 16'h0000, 1);
      expectEq("txInt count", 16'(txIntCount - txIntBefore), 16'h0001, 1);
    end

    // Second write during a frame is dropped.
    dataByte    = 8'($urandom);
    dataByte2   = ~dataByte;
    txIntBefore = txIntCount;
    txFramesWant++;
    txExpect.push_back(dataByte);
    busWrite(addrTxr, {8'h00, dataByte});
    repeat (2 * bitCycles) @(posedge clk);
    busWrite(addrTxr, {8'h00, dataByte2});
    wait (txFramesDone == txFramesWant);
    repeat (frameBits * bitCycles) @(posedge clk);
    expectEq("txInt count", 16'(txIntCount - txIntBefore), 16'h0001, 1);
    busRead(addrTxr, rdData);
    expectEq("txByte", rdData, {8'h00, dataByte}, 1);

    // Receive.
    for (int n = 0; n < numRx; n++) begin
      dataByte    = 8'($urandom);
      rxIntBefore = rxIntCount;
      sendRxFrame(dataByte);
      wait (rxIntCount == rxIntBefore + 1);
      busRead(addrCtl, rdData);
      status.raw = rdData;
      expectEq("rxNew", 16'(status.fields.rxNew), 16'h0001, 2);
      busRead(addrRxr, rdData);
      expectEq("rxByte", rdData, {8'h00, dataByte}, 2);
      busRead(addrCtl, rdData);
      status.raw = rdData;
      expectEq("rxNew", 16'(status.fields.rxNew), 16'h0000, 2);
      expectEq("rxInt count", 16'(rxIntCount - rxIntBefore), 16'h0001, 2);
    end

    // Disable mid-frame.
    dataByte    = 8'($urandom);
    txIntBefore = txIntCount;
    busWrite(addrTxr, {8'h00, dataByte});
    repeat (3 * bitCycles) @(posedge clk);
    busWrite(addrCtl, 16'h0000);
    busRead(addrCtl, rdData);
    status.raw = rdData;
    expectEq("txBusy", 16'(status.fields.txBusy), 16'h0000, 1);
    expectEq("enable", 16'(status.fields.enable), 16'h0000, 0);
    @(negedge clk);
    expectEq("txOut", 16'(txOut), 16'h0000, 1);
    repeat (frameBits * bitCycles) @(posedge clk);
    @(negedge clk);
    expectEq("txOut", 16'(txOut), 16'h0000, 1);
    expectEq("txInt count", 16'(txIntCount - txIntBefore), 16'h0000, 1);

    $display("Errors: register %0d, transmit %0d, receive %0d", errReg, errTx, errRx);
    if (errReg + errTx + errRx == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: build.f
common/uartPkg.sv
verilog/uartBusRegs.sv
uartTx/uartTx.sv
uartRx/uartRx.sv
verilog/uart.sv
test/uartTb.sv

// File: Bender.yml
package:
  name: uart

sources:
  # Shared package first.
  - common/uartPkg.sv
  # Register block and engines.
  - verilog/uartBusRegs.sv
  - uartTx/uartTx.sv
  - uartRx/uartRx.sv
  # Top level.
  - verilog/uart.sv
  # Testbench.
  - target: test
    files:
      - test/uartTb.sv
